//--- src/pipe_defines.svh
`ifndef PIPE_DEFINES_SVH
`define PIPE_DEFINES_SVH

// Architectural sizes of the integer pipeline

// Data word width
`define XLEN 64

// Number of integer registers, x0 included
`define REG_NUM 32

// Width of a register number, log2 of REG_NUM
`define REG_ADDR_W 5

`endif

//--- src/core_types_pkg.sv
`default_nettype none

`include "pipe_defines.svh"

package core_types_pkg;

    // One data word, operand or result
    typedef logic [`XLEN-1:0] xlen_t;

    // Register number as it appears in rs1, rs2 and rd
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // Operand source select code
    typedef enum logic [1:0] {
        src_file    = 2'b00, // Register file read port
        src_ex_alu  = 2'b01, // ALU result now in EX
        src_mm_alu  = 2'b10, // ALU result now in MM
        src_mm_load = 2'b11  // Load data returned in MM
    } bypass_src_e;

endpackage

`default_nettype wire

//--- src/pipe_stage_pkg.sv
`default_nettype none

package pipe_stage_pkg;

    // Result leaving EX, valid every cycle
    typedef struct packed {
        logic                      wr_en;      // Slot writes rd
        logic                      is_load;    // Load, result still to come from memory
        core_types_pkg::reg_addr_t rd;         // Destination register
        core_types_pkg::xlen_t     alu_result; // ALU result, address for a load
    } ex_result_t;

    // Same record one stage later
    typedef struct packed {
        logic                      wr_en;
        logic                      is_load;
        core_types_pkg::reg_addr_t rd;
        core_types_pkg::xlen_t     alu_result;
    } mm_stage_t;

    // Register file write at WB
    typedef struct packed {
        logic                      wr_en; // Commit this cycle
        core_types_pkg::reg_addr_t rd;    // Target, x0 ignored
        core_types_pkg::xlen_t     data;  // Load data or ALU result
    } wb_write_t;

    // Source registers from decode
    typedef struct packed {
        core_types_pkg::reg_addr_t rs1;
        core_types_pkg::reg_addr_t rs2;
    } operand_req_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

`include "pipe_defines.svh"

module reg_file (
    input  wire                          clk,
    input  wire                          rst_n,
    input  pipe_stage_pkg::wb_write_t    wb,   // WB commit
    input  core_types_pkg::reg_addr_t    rs1,
    input  core_types_pkg::reg_addr_t    rs2,
    output core_types_pkg::xlen_t        rd1,
    output core_types_pkg::xlen_t        rd2
);

    // x0 has no storage
    core_types_pkg::xlen_t regs [1:`REG_NUM-1];

    logic wr_hit; // Real write, not to x0

    assign wr_hit = wb.wr_en && (wb.rd != '0);

    // Write-first read, new WB data bypasses the array
    function automatic core_types_pkg::xlen_t read_port(
        input core_types_pkg::reg_addr_t rs
    );
        core_types_pkg::xlen_t value;
        if (rs == '0) begin
            value = '0;             // Hard-wired zero
        end else if (wr_hit && (wb.rd == rs)) begin
            value = wb.data;        // Same-cycle write
        end else begin
            value = regs[rs];
        end
        return value;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_NUM; i++) begin
                regs[i] <= '0;      // All registers read zero after reset
            end
        end else if (wr_hit) begin
            regs[wb.rd] <= wb.data;
        end
    end

    // Two independent read ports
    always_comb begin
        rd1 = read_port(rs1);
    end

    always_comb begin
        rd2 = read_port(rs2);
    end

endmodule

`default_nettype wire

//--- src/bypass_mux.sv
`timescale 1ns/1ps
`default_nettype none

module bypass_mux (
    input  core_types_pkg::reg_addr_t   rs,           // Source register of this operand
    input  core_types_pkg::xlen_t       file_out,     // Register file read, already write-first
    input  pipe_stage_pkg::ex_result_t  ex,           // Instruction in EX
    input  pipe_stage_pkg::mm_stage_t   mm,           // Instruction in MM
    input  core_types_pkg::xlen_t       mm_load_data, // Memory reply for MM
    output core_types_pkg::xlen_t       bypass_out
);

    logic                        rs_live; // x0 never forwards
    logic                        ex_hit;
    logic                        mm_hit;
    core_types_pkg::bypass_src_e bypass_sel;

    assign rs_live = (rs != '0);
    assign ex_hit  = rs_live && ex.wr_en && (ex.rd == rs);
    assign mm_hit  = rs_live && mm.wr_en && (mm.rd == rs);

    // Newest producer wins
    always_comb begin
        bypass_sel = core_types_pkg::src_file; // Default, no forwarding
        if (ex_hit) begin
            // A load in EX also lands here, but then the stall holds decode
            bypass_sel = core_types_pkg::src_ex_alu;
        end else if (mm_hit) begin
            if (mm.is_load) begin
                bypass_sel = core_types_pkg::src_mm_load;
            end else begin
                bypass_sel = core_types_pkg::src_mm_alu;
            end
        end
    end

    // Data select
    always_comb begin
        case (bypass_sel)
            core_types_pkg::src_ex_alu:  bypass_out = ex.alu_result;
            core_types_pkg::src_mm_alu:  bypass_out = mm.alu_result;
            core_types_pkg::src_mm_load: bypass_out = mm_load_data;
            default:                     bypass_out = file_out; // src_file
        endcase
    end

endmodule

`default_nettype wire

//--- src/hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect (
    input  pipe_stage_pkg::operand_req_t req, // Decode sources
    input  pipe_stage_pkg::ex_result_t   ex,  // Instruction in EX
    output logic                         stall
);

    logic load_in_ex; // Writing load with a real target
    logic rs1_hit;
    logic rs2_hit;

    // Load data only exists once the load reaches MM,
    // so a consumer right behind it has nothing to forward yet
    assign load_in_ex = ex.wr_en && ex.is_load && (ex.rd != '0);

    assign rs1_hit = (ex.rd == req.rs1); // x0 excluded by load_in_ex
    assign rs2_hit = (ex.rd == req.rs2);

    // One bubble is enough, MM forwarding covers the next cycle
    assign stall = load_in_ex && (rs1_hit || rs2_hit);

endmodule

`default_nettype wire

//--- src/stage_tracker.sv
`timescale 1ns/1ps
`default_nettype none

module stage_tracker (
    input  wire                         clk,
    input  wire                         rst_n,
    input  pipe_stage_pkg::ex_result_t  ex,           // Result leaving EX
    input  core_types_pkg::xlen_t       mm_load_data, // Memory reply for MM
    output pipe_stage_pkg::mm_stage_t   mm,
    output pipe_stage_pkg::wb_write_t   wb
);

    pipe_stage_pkg::mm_stage_t mm_q;
    pipe_stage_pkg::wb_write_t wb_next; // WB record built from MM
    pipe_stage_pkg::wb_write_t wb_q;

    // EX to MM
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mm_q.wr_en <= 1'b0; // Empty MM slot
        end else begin
            mm_q.wr_en      <= ex.wr_en;
            mm_q.is_load    <= ex.is_load;
            mm_q.rd         <= ex.rd;
            mm_q.alu_result <= ex.alu_result;
        end
    end

    // Merge the load data while still in MM
    always_comb begin
        wb_next.wr_en = mm_q.wr_en;
        wb_next.rd    = mm_q.rd;
        if (mm_q.is_load) begin
            wb_next.data = mm_load_data;    // Memory reply
        end else begin
            wb_next.data = mm_q.alu_result; // Plain ALU op
        end
    end

    // MM to WB
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q.wr_en <= 1'b0; // No write right after reset
        end else begin
            wb_q.wr_en <= wb_next.wr_en;
            wb_q.rd    <= wb_next.rd;
            wb_q.data  <= wb_next.data;
        end
    end

    assign mm = mm_q;
    assign wb = wb_q;

endmodule

`default_nettype wire

//--- src/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch (
    input  wire                          clk,
    input  wire                          rst_n,
    input  pipe_stage_pkg::ex_result_t   ex_result,    // EX result, every cycle
    input  core_types_pkg::xlen_t        mm_load_data, // Data memory reply for MM
    input  pipe_stage_pkg::operand_req_t req,          // rs1 and rs2 from decode
    output core_types_pkg::xlen_t        op1,
    output core_types_pkg::xlen_t        op2,
    output logic                         stall         // Load-use, insert a bubble
);

    pipe_stage_pkg::mm_stage_t mm;     // Registered EX record
    pipe_stage_pkg::wb_write_t wb;     // Registered WB write
    core_types_pkg::xlen_t     rf_rd1; // Register file, rs1 port
    core_types_pkg::xlen_t     rf_rd2; // Register file, rs2 port

    stage_tracker i_stage_tracker (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex           (ex_result),
        .mm_load_data (mm_load_data),
        .mm           (mm),
        .wb           (wb)
    );

    reg_file i_reg_file (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb),
        .rs1   (req.rs1),
        .rs2   (req.rs2),
        .rd1   (rf_rd1),
        .rd2   (rf_rd2)
    );

    // Operand 1
    bypass_mux i_bypass_rs1 (
        .rs           (req.rs1),
        .file_out     (rf_rd1),
        .ex           (ex_result),
        .mm           (mm),
        .mm_load_data (mm_load_data),
        .bypass_out   (op1)
    );

    // Operand 2
    bypass_mux i_bypass_rs2 (
        .rs           (req.rs2),
        .file_out     (rf_rd2),
        .ex           (ex_result),
        .mm           (mm),
        .mm_load_data (mm_load_data),
        .bypass_out   (op2)
    );

    hazard_detect i_hazard_detect (
        .req   (req),
        .ex    (ex_result),
        .stall (stall)
    );

endmodule

`default_nettype wire

//--- verification/operand_fetch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_VECTORS  = 30;   // Lines in the vector file
    localparam int NUM_COLS     = 10;   // Tokens per line
    localparam int CYCLE_LIMIT  = RESET_CYCLES + NUM_VECTORS + 20;

    // One cycle of stimulus plus expected response
    typedef struct packed {
        pipe_stage_pkg::ex_result_t   ex;
        core_types_pkg::xlen_t        load_data;
        pipe_stage_pkg::operand_req_t req;
        core_types_pkg::xlen_t        exp_op1;
        core_types_pkg::xlen_t        exp_op2;
        logic                         exp_stall;
    } vector_t;

    logic                         clk;
    logic                         rst_n;
    pipe_stage_pkg::ex_result_t   ex_result;
    core_types_pkg::xlen_t        mm_load_data;
    pipe_stage_pkg::operand_req_t req;
    core_types_pkg::xlen_t        op1;
    core_types_pkg::xlen_t        op2;
    logic                         stall;

    core_types_pkg::xlen_t raw_tokens [0:NUM_VECTORS*NUM_COLS-1]; // Flat copy of the file
    int                    cycle_count = 0;

    operand_fetch i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .ex_result    (ex_result),
        .mm_load_data (mm_load_data),
        .req          (req),
        .op1          (op1),
        .op2          (op2),
        .stall        (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // Watchdog on total run length
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("The run exceeded its limit of %0d clock cycles", CYCLE_LIMIT);
            stop_with_failure();
        end
    end

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic compare_data(
        input string                 name,
        input core_types_pkg::xlen_t actual,
        input core_types_pkg::xlen_t expected
    );
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %h, expected %h",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    task automatic compare_stall(
        input string name,
        input logic  actual,
        input logic  expected
    );
        if (actual !== expected) begin
            $display("** Error at %0t ns: %s is %b, expected %b",
                     $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    // Unpack one file line into a cycle record
    function automatic vector_t vector_at(input int idx);
        vector_t v;
        int      base;
        base = idx * NUM_COLS;
        v.ex.wr_en      = raw_tokens[base][0];
        v.ex.is_load    = raw_tokens[base + 1][0];
        v.ex.rd         = core_types_pkg::reg_addr_t'(raw_tokens[base + 2]);
        v.ex.alu_result = raw_tokens[base + 3];
        v.load_data     = raw_tokens[base + 4];  // Reply for whatever sits in MM
        v.req.rs1       = core_types_pkg::reg_addr_t'(raw_tokens[base + 5]);
        v.req.rs2       = core_types_pkg::reg_addr_t'(raw_tokens[base + 6]);
        v.exp_op1       = raw_tokens[base + 7];
        v.exp_op2       = raw_tokens[base + 8];
        v.exp_stall     = raw_tokens[base + 9][0];
        return v;
    endfunction

    initial begin
        vector_t vec;
        rst_n        = 1'b0;
        ex_result    = '0;  // Empty EX slot during reset
        mm_load_data = '0;
        req          = '0;
        $readmemh("verification/operand_vectors.hex", raw_tokens);
        if ($isunknown(raw_tokens[NUM_VECTORS*NUM_COLS-1])) begin
            $display("The vector file is missing or has fewer than %0d lines", NUM_VECTORS);
            stop_with_failure();
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            for (int i = 0; i < NUM_VECTORS; i++) begin
                vec          = vector_at(i);
                ex_result    = vec.ex;
                mm_load_data = vec.load_data;
                req          = vec.req;
                #(CLK_PERIOD / 2 - 1);  // Sample 1 ns ahead of the rising edge
                compare_data($sformatf("op1 (vector %0d)", i), op1, vec.exp_op1);
                compare_data($sformatf("op2 (vector %0d)", i), op2, vec.exp_op2);
                compare_stall($sformatf("stall (vector %0d)", i), stall, vec.exp_stall);
                @(negedge clk);
            end
            $display("test passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- build.f
+incdir+src
src/core_types_pkg.sv
src/pipe_stage_pkg.sv
src/reg_file.sv
src/bypass_mux.sv
src/hazard_detect.sv
src/stage_tracker.sv
src/operand_fetch.sv
verification/operand_fetch_tb.sv

//--- Makefile
BIN = obj_dir/Voperand_fetch_tb
SRC = $(wildcard src/*.sv src/*.svh verification/*.sv)

.PHONY: run clean

# Run from the project root so the vector file path resolves
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "test passed"

$(BIN): build.f $(SRC)
	verilator --binary --timing -j 0 --Mdir obj_dir \
		--top-module operand_fetch_tb -f build.f

clean:
	rm -rf obj_dir

//--- verification/operand_vectors.hex
// Columns: wr_en is_load rd alu_result mm_load_data rs1 rs2 exp_op1 exp_op2 exp_stall
// One line per cycle after reset, all hex, mm_load_data answers the slot now in MM
// Reads right after reset
0 0 00 0 0 01 1f 0 0 0
0 0 00 0 0 05 0a 0 0 0
// x0 ignores writes from EX, MM and WB
1 0 00 deadbeef 0 00 00 0 0 0
1 1 00 100 0 00 00 0 0 0
0 0 00 0 cafe 00 00 0 0 0
0 0 00 0 0 00 01 0 0 0
// EX beats MM on the same register
1 0 03 11110000 0 03 00 11110000 0 0
1 0 03 2222 0 03 03 2222 2222 0
1 1 04 400 0 03 05 2222 0 0
1 0 04 4444 beef 04 03 4444 2222 0
// MM forwards load data or ALU result
0 0 00 0 0 04 03 4444 2222 0
1 1 06 600 0 07 08 0 0 0
1 0 07 7777 6666 06 07 6666 7777 0
1 0 08 8888 abcd 07 06 7777 6666 0
// x9 through EX, MM, write-first WB, then the file
1 0 09 0123456789abcdef 0 09 07 0123456789abcdef 7777 0
0 0 00 0 0 09 08 0123456789abcdef 8888 0
0 0 00 0 0 09 06 0123456789abcdef 6666 0
0 0 00 0 0 09 07 0123456789abcdef 7777 0
0 0 00 0 0 04 08 4444 8888 0
// Load-use stall, one bubble, then MM load forward
1 1 0a 1000 0 0a 03 1000 2222 1
0 0 00 0 fedcba9876543210 0a 03 fedcba9876543210 2222 0
1 1 0b 2000 0 05 0b 0 2000 1
0 0 00 0 5555aaaa5555aaaa 05 0b 0 5555aaaa5555aaaa 0
1 1 00 3000 0 00 0a 0 fedcba9876543210 0
1 1 0c 4000 9999 0c 0c 4000 4000 1
0 0 00 0 0c0c0c0c 0c 0b 0c0c0c0c 5555aaaa5555aaaa 0
1 1 0d 5000 0 0c 0a 0c0c0c0c fedcba9876543210 0
// Load slot without wr_en raises no stall
0 1 0c 6000 dddd 0c 0d 0c0c0c0c dddd 0
0 0 00 0 0 0d 0c dddd 0c0c0c0c 0
0 0 00 0 0 0a 0b fedcba9876543210 5555aaaa5555aaaa 0
